/* flist.f */
+incdir+.
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_tb.sv

/* Makefile */
# Verilator build and run of the UART testbench

TOP       ?= uart_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell grep -v '^+' $(FLIST))
HEADERS   := $(wildcard *.svh)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* uart_tb_tasks.svh */
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// line bits of one frame, bit 0 first on the wire
function automatic logic [FRAME_BITS-1:0] build_line_frame(input data_t w,
                                                           input logic flip_parity,
                                                           input logic low_stop);
	logic [FRAME_BITS-1:0] f;
	f[0]              = 1'b0;                       // start bit
	f[DATA_WIDTH:1]   = w;                          // data lsb first
	f[DATA_WIDTH+1]   = (^w) ^ flip_parity;         // even parity
	f[DATA_WIDTH+2]   = !low_stop;                  // stop bit
	return f;
endfunction

task automatic report_test(input string name, input int errs_at_start);
	$display("%s: %s (%0d errors)", name, (errors == errs_at_start) ? "ok" : "failed",
	         errors - errs_at_start);
endtask

task automatic wait_tx_idle();
	int n;
	n = 0;
	while (tx_busy && n < 2 * FRAME_CYCLES) begin
		@(negedge tx_clk);
		n++;
	end
	if (tx_busy) begin
		$display("Error at %0t ns: transmitter stayed busy for %0d cycles", $time, n);
		errors++;
	end
endtask

// one-cycle strobe; returns on the negedge after the accepting clock edge
task automatic send_word(input data_t w);
	wait_tx_idle();
	tx_data   = w;
	tx_enable = 1'b1;
	@(negedge tx_clk);
	tx_enable = 1'b0;
endtask

task automatic wait_for_frames(input int target);
	int n;
	n = 0;
	while (rx_frames < target && n < 2 * FRAME_CYCLES) begin
		@(negedge tx_clk);
		n++;
	end
	if (rx_frames < target) begin
		$display("Error at %0t ns: no frame arrived on o_rx_valid within %0d cycles",
		         $time, n);
		errors++;
	end
endtask

// bit-bang one frame onto the rx line, tx idles high meanwhile
task automatic force_frame(input data_t w, input logic flip_parity, input logic low_stop);
	logic [FRAME_BITS-1:0] bits;
	int i;
	bits = build_line_frame(w, flip_parity, low_stop);
	wait_tx_idle();
	forced_bit = 1'b1;
	force_line = 1'b1;
	for (i = 0; i < FRAME_BITS; i++) begin
		forced_bit = bits[i];
		repeat (CPB) @(negedge tx_clk);
	end
	forced_bit = 1'b1;
	repeat (CPB) @(negedge tx_clk);                 // one idle bit before release
	force_line = 1'b0;
endtask

task automatic reset_state();
	int errs;
	errs = errors;
	compare_values("o_serial_out", 32'(serial_out), 32'd1);
	compare_values("o_tx_busy", 32'(tx_busy), 32'd0);
	compare_values("o_rx_valid", 32'(rx_valid), 32'd0);
	compare_values("o_rx_error", 32'(rx_error), 32'd0);
	compare_values("o_rx_data", 32'(rx_data), 32'd0);
	report_test("reset state", errs);
endtask

task automatic frame_shape();
	data_t w;
	logic [FRAME_BITS-1:0] exp;
	int errs;
	int base;
	int i;
	errs = errors;
	base = rx_frames;
	w    = data_t'($random(seed));
	exp  = build_line_frame(w, 1'b0, 1'b0);
	send_word(w);
	repeat (CPB / 2) @(negedge tx_clk);             // middle of the start bit
	for (i = 0; i < FRAME_BITS; i++) begin
		compare_values($sformatf("o_serial_out bit %0d", i), 32'(serial_out), 32'(exp[i]));
		if (i < FRAME_BITS - 1) begin
			repeat (CPB) @(negedge tx_clk);
		end
	end
	repeat (CPB / 2 - 1) @(negedge tx_clk);         // last cycle of the stop bit
	compare_values("o_tx_busy before end", 32'(tx_busy), 32'd1);
	@(negedge tx_clk);
	compare_values("o_tx_busy at end", 32'(tx_busy), 32'd0);
	wait_for_frames(base + 1);                      // loopback copy of this word
	compare_values("o_rx_data", 32'(rx_data), 32'(w));
	report_test("frame shape", errs);
endtask

task automatic loopback_words();
	data_t fixed_words [3] = '{8'h00, 8'hff, 8'ha5};
	data_t w;
	int errs;
	int base;
	int i;
	errs = errors;
	for (i = 0; i < 23; i++) begin
		w    = (i < 3) ? fixed_words[i] : data_t'($random(seed));
		base = rx_frames;
		send_word(w);
		wait_for_frames(base + 1);
		compare_values("o_rx_data", 32'(rx_data), 32'(w));
		compare_values("o_rx_error", 32'(rx_error), 32'd0);
	end
	report_test("loopback words", errs);
endtask

task automatic busy_strobe_ignored();
	data_t first;
	data_t second;
	int errs;
	int base;
	errs   = errors;
	base   = rx_frames;
	first  = data_t'($random(seed));
	second = ~first;
	send_word(first);
	repeat (3 * CPB) @(negedge tx_clk);             // well inside the frame
	compare_values("o_tx_busy", 32'(tx_busy), 32'd1);
	tx_data   = second;
	tx_enable = 1'b1;                               // must be dropped
	@(negedge tx_clk);
	tx_enable = 1'b0;
	wait_for_frames(base + 1);
	repeat (FRAME_CYCLES) @(negedge tx_clk);        // listen for a second frame
	compare_values("o_rx_valid pulses", rx_frames - base, 32'd1);
	compare_values("o_rx_data", 32'(rx_data), 32'(first));
	report_test("busy strobe ignored", errs);
endtask

task automatic parity_error_frame();
	data_t w;
	int errs;
	int base;
	errs = errors;
	w    = data_t'($random(seed));
	base = rx_frames;
	force_frame(w, 1'b1, 1'b0);
	wait_for_frames(base + 1);
	compare_values("o_rx_data", 32'(rx_data), 32'(w));  // data still delivered
	compare_values("o_rx_error", 32'(rx_error), 32'd1);
	w    = data_t'($random(seed));
	base = rx_frames;
	send_word(w);                                   // good frame clears the flag
	wait_for_frames(base + 1);
	compare_values("o_rx_data", 32'(rx_data), 32'(w));
	compare_values("o_rx_error", 32'(rx_error), 32'd0);
	report_test("parity error", errs);
endtask

task automatic framing_error_and_glitch();
	data_t w;
	int errs;
	int base;
	errs = errors;
	w    = data_t'($random(seed));
	base = rx_frames;
	force_frame(w, 1'b0, 1'b1);
	wait_for_frames(base + 1);
	compare_values("o_rx_data", 32'(rx_data), 32'(w));
	compare_values("o_rx_error", 32'(rx_error), 32'd1);
	base       = rx_frames;
	forced_bit = 1'b0;
	force_line = 1'b1;
	repeat (CPB / 2 - 1) @(negedge tx_clk);         // shorter than half a bit
	forced_bit = 1'b1;
	force_line = 1'b0;
	repeat (FRAME_CYCLES) @(negedge tx_clk);
	compare_values("o_rx_valid pulses", rx_frames - base, 32'd0);
	report_test("framing error and false start", errs);
endtask

`endif

/* uart_tb.sv */
`timescale 1ns/1ns

module uart_tb;
	import uart_pkg::*;

	localparam int CPB          = 8;                    // matches the DUT default
	localparam int CLK_PERIOD   = 100;                  // ns
	localparam int FRAME_CYCLES = FRAME_BITS * CPB;     // one frame on the line
	// shape 1, loopback 23, busy 2 (incl listen window), parity 2, framing 1 + glitch 1
	localparam int NUM_FRAMES   = 30;
	localparam int WATCHDOG_NS  = NUM_FRAMES * FRAME_CYCLES * CLK_PERIOD * 2;

	logic   tx_clk;
	logic   reset;
	logic   tx_enable;                                  // strobe into the DUT
	data_t  tx_data;
	logic   tx_busy;
	logic   serial_out;                                 // tx line from the DUT
	logic   serial_in;                                  // rx line into the DUT
	data_t  rx_data;
	logic   rx_valid;
	logic   rx_error;
	logic   force_line;                                 // 1 = testbench owns the rx line
	logic   forced_bit;                                 // bit-banged line level
	integer seed;
	int     rx_frames;                                  // valid pulses seen so far
	int     passes;
	int     errors;

	// loopback unless a test bit-bangs the line itself
	assign serial_in = force_line ? forced_bit : serial_out;

	uart_top i_uart_top (
		.tx_clk       (tx_clk),
		.reset        (reset),
		.i_tx_enable  (tx_enable),
		.i_tx_data    (tx_data),
		.o_tx_busy    (tx_busy),
		.o_serial_out (serial_out),
		.i_serial_in  (serial_in),
		.o_rx_data    (rx_data),
		.o_rx_valid   (rx_valid),
		.o_rx_error   (rx_error)
	);

	initial begin
		tx_clk = 1'b0;
		forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;      // 100 ns period
	end

	// count valid pulses so short pulses are never missed by a busy test
	always @(posedge tx_clk) begin
		if (rx_valid) begin
			rx_frames <= rx_frames + 1;
		end
	end

	task automatic compare_values(input string name, input logic [31:0] actual,
	                              input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s actual 0x%0h expected 0x%0h",
			         $time, name, actual, expected);
			errors++;
		end else begin
			passes++;
		end
	endtask

	`include "uart_tb_tasks.svh"

	initial begin
		seed       = 32'hbb98b73d;
		passes     = 0;
		errors     = 0;
		reset      = 1'b1;
		tx_enable  = 1'b0;
		tx_data    = '0;
		force_line = 1'b0;
		forced_bit = 1'b1;                              // idle level
		repeat (4) @(posedge tx_clk);                   // 4 reset cycles
		@(negedge tx_clk);
		reset = 1'b0;
		reset_state();
		frame_shape();
		loopback_words();
		busy_strobe_ignored();
		parity_error_frame();
		framing_error_and_glitch();
		$display("checks passed: %0d, errors: %0d", passes, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// twice the time that all frames of the run need
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* uart_top.sv */
`timescale 1ns/1ns

module uart_top #(
	parameter int CLOCKS_PER_BIT = 8,               // even, at least 4
	parameter int PARITY_ODD     = 0                // 0 even parity, 1 odd parity
) (
	input  logic            tx_clk,                 // single clock for both halves
	input  logic            reset,                  // sync, active high

	// transmitter side
	input  logic            i_tx_enable,            // start strobe
	input  uart_pkg::data_t i_tx_data,              // word to send
	output logic            o_tx_busy,              // frame in flight
	output logic            o_serial_out,           // serial line out

	// receiver side
	input  logic            i_serial_in,            // serial line in
	output uart_pkg::data_t o_rx_data,              // received word
	output logic            o_rx_valid,             // one cycle per frame
	output logic            o_rx_error              // parity or framing error
);

	// transmitter
	uart_tx #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY_ODD     (PARITY_ODD)
	) i_uart_tx (
		.tx_clk       (tx_clk),
		.reset        (reset),
		.i_enable     (i_tx_enable),
		.i_data       (i_tx_data),
		.o_busy       (o_tx_busy),
		.o_serial_out (o_serial_out)
	);

	// receiver, line comes from outside so a loopback lives in the testbench
	uart_rx #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY_ODD     (PARITY_ODD)
	) i_uart_rx (
		.tx_clk      (tx_clk),
		.reset       (reset),
		.i_serial_in (i_serial_in),
		.o_data      (o_rx_data),
		.o_valid     (o_rx_valid),
		.o_error     (o_rx_error)
	);

endmodule

/* uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
	parameter int CLOCKS_PER_BIT = 8,               // tx_clk cycles per serial bit
	parameter int PARITY_ODD     = 0                // 0 even parity, 1 odd parity
) (
	input  logic            tx_clk,
	input  logic            reset,                  // sync, active high
	input  logic            i_serial_in,            // async serial line
	output uart_pkg::data_t o_data,                 // last received word
	output logic            o_valid,                // one cycle per frame
	output logic            o_error                 // parity or stop bit wrong
);
	import uart_pkg::*;

	localparam int CNT_W  = $clog2(CLOCKS_PER_BIT);
	localparam int DBIT_W = $clog2(DATA_WIDTH);
	localparam logic [CNT_W-1:0]  CNT_LAST  = CNT_W'(CLOCKS_PER_BIT - 1);    // mid of next bit
	localparam logic [CNT_W-1:0]  CNT_HALF  = CNT_W'(CLOCKS_PER_BIT / 2 - 1); // mid of start bit
	localparam logic [DBIT_W-1:0] DBIT_LAST = DBIT_W'(DATA_WIDTH - 1);
	localparam logic ODD = (PARITY_ODD != 0);

	// fsm states
	localparam logic [2:0] S_IDLE   = 3'd0;       // wait for falling edge
	localparam logic [2:0] S_START  = 3'd1;       // confirm start bit at mid-bit
	localparam logic [2:0] S_DATA   = 3'd2;       // eight data bits
	localparam logic [2:0] S_PARITY = 3'd3;
	localparam logic [2:0] S_STOP   = 3'd4;

	logic [2:0]        sync;                        // three flop synchronizer
	logic              line;                        // synchronized line
	logic              line_d;                      // line one cycle back
	logic              fall;                        // falling edge on line
	logic [2:0]        state;
	logic [CNT_W-1:0]  cnt;                         // cycles since last sample
	logic [DBIT_W-1:0] bit_cnt;                     // data bits taken
	logic              sample;                      // mid-bit strobe
	logic              shift_en;                    // take line into frame
	uart_frame_u       frame;                       // sipo shift register
	uart_frame_u       frame_next;                  // frame including current sample
	logic              parity_bad;
	logic              stop_bad;

	assign line   = sync[2];
	assign fall   = line_d && !line;
	assign sample = (cnt == CNT_LAST);

	// synchronizer and edge detector, preset to the idle level
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			sync   <= 3'b111;
			line_d <= 1'b1;
		end else begin
			sync   <= {sync[1:0], i_serial_in};
			line_d <= line;
		end
	end

	// samples enter at the msb so the start bit ends up in bit 0
	always_comb begin
		frame_next.raw = {line, frame.raw[FRAME_BITS-1:1]};
	end

	// shift on the start check and on every later sample
	assign shift_en = (state == S_START) ? (cnt == CNT_HALF) :
	                  ((state != S_IDLE) && sample);

	always_ff @(posedge tx_clk) begin
		if (shift_en) begin
			frame <= frame_next;
		end
	end

	// frame checks read the field view of the completed frame
	assign parity_bad = (frame_next.fields.parity_bit !=
	                     calc_parity(frame_next.fields.data, ODD));
	assign stop_bad   = !frame_next.fields.stop_bit;  // framing error

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			state   <= S_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			o_valid <= 1'b0;
			o_data  <= '0;
			o_error <= 1'b0;
		end else begin
			o_valid <= 1'b0;                        // pulse default
			cnt     <= cnt + 1'b1;
			case (state)
				S_IDLE: begin
					if (fall) begin
						state <= S_START;
						cnt   <= CNT_W'(1);         // edge cycle counts as one
					end
				end
				S_START: begin
					if (cnt == CNT_HALF) begin
						cnt     <= '0;
						bit_cnt <= '0;
						if (line) begin
							state <= S_IDLE;        // glitch, not a start bit
						end else begin
							state <= S_DATA;
						end
					end
				end
				S_DATA: begin
					if (sample) begin
						cnt     <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == DBIT_LAST) begin
							state <= S_PARITY;
						end
					end
				end
				S_PARITY: begin
					if (sample) begin
						cnt   <= '0;
						state <= S_STOP;
					end
				end
				S_STOP: begin
					if (sample) begin
						cnt     <= '0;
						state   <= S_IDLE;          // rearm at mid stop bit
						o_valid <= 1'b1;
						o_data  <= frame_next.fields.data;  // delivered even on error
						o_error <= parity_bad || stop_bad;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// a frame takes many cycles so valid can never repeat back to back
	a_valid_pulse: assert property (
		@(posedge tx_clk) disable iff (reset)
		o_valid |=> !o_valid
	);

	// no stale valid right after a reset cycle
	a_valid_after_reset: assert property (
		@(posedge tx_clk)
		reset |=> !o_valid
	);

endmodule

/* uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
	parameter int CLOCKS_PER_BIT = 8,               // tx_clk cycles per serial bit
	parameter int PARITY_ODD     = 0                // 0 even parity, 1 odd parity
) (
	input  logic            tx_clk,
	input  logic            reset,                  // sync, active high
	input  logic            i_enable,               // one cycle start strobe
	input  uart_pkg::data_t i_data,                 // word to send
	output logic            o_busy,                 // frame in flight
	output logic            o_serial_out            // serial line, idles high
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);  // baud counter width
	localparam int BIT_W = $clog2(FRAME_BITS);      // frame bit counter width
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLOCKS_PER_BIT - 1);
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(FRAME_BITS - 1);
	localparam logic ODD = (PARITY_ODD != 0);

	logic [CNT_W-1:0] baud_cnt;                     // cycles into current bit
	logic [BIT_W-1:0] bit_cnt;                      // bits already on the line
	logic             baud_tick;                    // last cycle of a bit
	logic             start;                        // strobe accepted
	uart_frame_u      load_frame;                   // frame built from i_data
	uart_frame_u      frame;                        // piso shift register

	assign start     = i_enable && !o_busy;         // strobes while busy are dropped
	assign baud_tick = (baud_cnt == CNT_LAST);

	// build the frame through the field view
	always_comb begin
		load_frame.fields.start_bit  = 1'b0;
		load_frame.fields.data       = i_data;
		load_frame.fields.parity_bit = calc_parity(i_data, ODD);
		load_frame.fields.stop_bit   = 1'b1;
	end

	// whole frame, shifted right at the end of each bit with idle ones behind it
	always_ff @(posedge tx_clk) begin
		if (start) begin
			frame <= load_frame;                    // capture word with the strobe
		end else if (o_busy && baud_tick) begin
			frame.raw <= {1'b1, frame.raw[FRAME_BITS-1:1]};  // next bit into bit 0
		end
	end

	// baud counter restarts on the strobe so bit edges line up with it
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			baud_cnt <= '0;
		end else if (!o_busy) begin
			baud_cnt <= '0;                         // hold at zero while idle
		end else if (baud_tick) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// bit counter and busy flag
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			bit_cnt <= '0;
			o_busy  <= 1'b0;
		end else if (start) begin
			bit_cnt <= '0;
			o_busy  <= 1'b1;                        // busy together with start bit
		end else if (o_busy && baud_tick) begin
			if (bit_cnt == BIT_LAST) begin
				bit_cnt <= '0;
				o_busy  <= 1'b0;                    // end of stop bit
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// line driver, registered from bit 0 of the frame
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			o_serial_out <= 1'b1;                   // idle level
		end else if (start) begin
			o_serial_out <= load_frame.raw[0];      // start bit right after the strobe
		end else if (o_busy && baud_tick) begin
			o_serial_out <= frame.raw[1];           // bit 0 after this shift, idle one after stop
		end
	end

	// line must idle high whenever no frame is in flight
	a_idle_high: assert property (
		@(posedge tx_clk) disable iff (reset)
		!o_busy |-> o_serial_out
	);

	// an accepted strobe starts a frame on the next cycle, start bit on the line
	a_start_busy: assert property (
		@(posedge tx_clk) disable iff (reset)
		(i_enable && !o_busy) |=> (o_busy && !o_serial_out)
	);

endmodule

/* uart_pkg.sv */
package uart_pkg;

	localparam int DATA_WIDTH = 8;                  // payload bits per frame
	localparam int FRAME_BITS = DATA_WIDTH + 3;     // start + data + parity + stop

	typedef logic [DATA_WIDTH-1:0] data_t;          // payload word

	// one frame word with two views
	// raw is what goes on the line and bit 0 is sent first
	typedef union packed {
		logic [FRAME_BITS-1:0] raw;                 // shift view
		struct packed {
			logic  stop_bit;                        // msb and sent last
			logic  parity_bit;
			data_t data;                            // sent lsb first
			logic  start_bit;                       // lsb and sent first
		} fields;                                   // field view
	} uart_frame_u;

	// parity bit for a payload word
	// even parity gives the plain xor and odd parity its inverse
	function automatic logic calc_parity(
		input data_t data,
		input logic  odd
	);
		logic par;
		par = ^data;                                // even parity
		return par ^ odd;                           // flip for odd parity
	endfunction

endpackage
